//--- hdl/icachePkg.sv
// Geometry constants and the fetch address type shared by the instruction cache.
// Modules pull these in with a wildcard import in their headers.
package icachePkg;

    // fixed geometry
    localparam int ADDR_BITS = 32;
    localparam int WORD_BITS = 32;
    localparam int BLOCK_WORDS = 4;
    localparam int BLOCK_BITS = WORD_BITS * BLOCK_WORDS;
    localparam int SETS = 16;
    localparam int INDEX_BITS = $clog2(SETS);
    localparam int TAG_BITS = ADDR_BITS - INDEX_BITS - $clog2(BLOCK_WORDS) - 2;
    localparam int BLOCK_ADDR_BITS = TAG_BITS + INDEX_BITS;

    // field view of a byte address, tag in the top bits
    typedef struct packed {
        logic [TAG_BITS-1:0] tag;
        logic [INDEX_BITS-1:0] index;
        logic [$clog2(BLOCK_WORDS)-1:0] wordSel;
        logic [1:0] byteOff;
    } fetchFieldsT;

    // one fetch address, read either as a raw word or by field
    typedef union packed {
        logic [ADDR_BITS-1:0] raw;
        fetchFieldsT fields;
    } fetchAddrT;

    // word n of a block sits at bits [32n+31:32n]

endpackage

//--- hdl/fetchPort.sv
// CPU side of the instruction cache. Answers the four-phase fetch handshake,
// holds the fetch address for the controller and picks the requested word
// out of the block the controller hands back.
`timescale 1ns/1ps

module fetchPort import icachePkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic cpuReq,
    input  fetchAddrT cpuAddr,
    input  logic [BLOCK_BITS-1:0] lineData,
    input  logic lineDone,
    output logic cpuAck,
    output logic [WORD_BITS-1:0] cpuData,
    output logic lookupStart,
    output fetchAddrT fetchAddr
);

    typedef enum logic [1:0] {stIdle, stBusy, stAck} stateT;

    stateT state;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= stIdle;
            cpuAck <= 1'b0;
            lookupStart <= 1'b0;
        end else begin
            lookupStart <= 1'b0;
            case (state)
                stIdle: begin
                    if (cpuReq) begin
                        lookupStart <= 1'b1;
                        state <= stBusy;
                    end
                end
                stBusy: begin
                    if (lineDone) begin
                        cpuAck <= 1'b1;
                        state <= stAck;
                    end
                end
                // hold the answer until the CPU lets go of the request
                default: begin
                    if (!cpuReq) begin
                        cpuAck <= 1'b0;
                        state <= stIdle;
                    end
                end
            endcase
        end
    end

    // address and returned word
    always_ff @(posedge clk) begin
        if (state == stIdle && cpuReq) begin
            fetchAddr <= cpuAddr;
        end
        if (state == stBusy && lineDone) begin
            cpuData <= lineData[fetchAddr.fields.wordSel * WORD_BITS +: WORD_BITS];
        end
    end

endmodule

//--- hdl/cacheArray.sv
// Tag and data storage of the set-associative instruction cache.
// Reads and hit detection are combinational on the lookup tag and index;
// touch updates the MRU bits of the hit way, fill writes the victim way.
`timescale 1ns/1ps

module cacheArray import icachePkg::*; #(
    parameter int WAYS = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic [TAG_BITS-1:0] lookupTag,
    input  logic [INDEX_BITS-1:0] lookupIndex,
    input  logic touch,
    input  logic fill,
    input  logic [BLOCK_BITS-1:0] fillData,
    output logic hit,
    output logic [BLOCK_BITS-1:0] hitData
);

    localparam int WAY_BITS = $clog2(WAYS);

    logic [WAYS-1:0] validBits [SETS];
    logic [WAYS-1:0] mruBits [SETS];
    logic [TAG_BITS-1:0] tagMem [SETS][WAYS];
    logic [BLOCK_BITS-1:0] dataMem [SETS][WAYS];

    logic [WAYS-1:0] hitVec;
    logic [WAY_BITS-1:0] hitWay;
    logic [WAY_BITS-1:0] victimWay;
    logic [WAY_BITS-1:0] accessWay;
    logic [WAYS-1:0] accessMask;
    logic [WAYS-1:0] mruNext;

    // compare every way of the indexed set
    always_comb begin
        hitVec = '0;
        hitWay = '0;
        for (int w = 0; w < WAYS; w++) begin
            hitVec[w] = validBits[lookupIndex][w] && (tagMem[lookupIndex][w] == lookupTag);
        end
        // walk down so the lowest matching way wins
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (hitVec[w]) begin
                hitWay = WAY_BITS'(w);
            end
        end
    end

    assign hit = |hitVec;
    assign hitData = dataMem[lookupIndex][hitWay];

    // victim is the lowest invalid way, else the lowest way not recently used
    always_comb begin
        victimWay = '0;
        if (&validBits[lookupIndex]) begin
            for (int w = WAYS - 1; w >= 0; w--) begin
                if (!mruBits[lookupIndex][w]) begin
                    victimWay = WAY_BITS'(w);
                end
            end
        end else begin
            for (int w = WAYS - 1; w >= 0; w--) begin
                if (!validBits[lookupIndex][w]) begin
                    victimWay = WAY_BITS'(w);
                end
            end
        end
    end

    // MRU update, restart from the accessed way when the set would fill up
    assign accessWay = fill ? victimWay : hitWay;
    assign accessMask = WAYS'(1) << accessWay;

    always_comb begin
        mruNext = mruBits[lookupIndex] | accessMask;
        if (&mruNext) begin
            mruNext = accessMask;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < SETS; s++) begin
                validBits[s] <= '0;
                mruBits[s] <= '0;
            end
        end else begin
            if (touch || fill) begin
                mruBits[lookupIndex] <= mruNext;
            end
            if (fill) begin
                validBits[lookupIndex][victimWay] <= 1'b1;
            end
        end
    end

    // tag and block of the refilled way
    always_ff @(posedge clk) begin
        if (fill) begin
            tagMem[lookupIndex][victimWay] <= lookupTag;
            dataMem[lookupIndex][victimWay] <= fillData;
        end
    end

endmodule

//--- hdl/memPort.sv
// Memory side of the instruction cache. Fetches one block per refill over the
// four-phase memory handshake and hands it to the controller with fillDone.
// The wait for the ack to drop runs on after fillDone.
`timescale 1ns/1ps

module memPort import icachePkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic fillStart,
    input  logic [BLOCK_ADDR_BITS-1:0] fillAddr,
    input  logic memAck,
    input  logic [BLOCK_BITS-1:0] memData,
    output logic memReq,
    output logic [BLOCK_ADDR_BITS-1:0] memAddr,
    output logic fillDone,
    output logic [BLOCK_BITS-1:0] fillData
);

    typedef enum logic [1:0] {stIdle, stWaitAck, stWaitLow} stateT;

    stateT state;
    // refill asked for while the last ack is still high
    logic pending;
    logic startNow;

    assign startNow = (state == stIdle) && (fillStart || pending);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= stIdle;
            memReq <= 1'b0;
            fillDone <= 1'b0;
            pending <= 1'b0;
        end else begin
            fillDone <= 1'b0;
            if (fillStart && state != stIdle) begin
                pending <= 1'b1;
            end
            case (state)
                stIdle: begin
                    if (startNow) begin
                        memReq <= 1'b1;
                        pending <= 1'b0;
                        state <= stWaitAck;
                    end
                end
                stWaitAck: begin
                    if (memAck) begin
                        memReq <= 1'b0;
                        fillDone <= 1'b1;
                        state <= stWaitLow;
                    end
                end
                default: begin
                    if (!memAck) begin
                        state <= stIdle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (startNow) begin
            memAddr <= fillAddr;
        end
        if (state == stWaitAck && memAck) begin
            fillData <= memData;
        end
    end

endmodule

//--- hdl/cacheCtrl.sv
// Lookup and miss controller. Checks the array for each fetch, hands a hit line
// straight back, or runs a refill through the memory port, writes the block
// into the array and then returns it to the fetch port.
`timescale 1ns/1ps

module cacheCtrl import icachePkg::*; #(
    parameter int WAYS = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic lookupStart,
    input  fetchAddrT fetchAddr,
    input  logic hit,
    input  logic [BLOCK_BITS-1:0] hitData,
    input  logic fillDone,
    input  logic [BLOCK_BITS-1:0] fillData,
    output logic [TAG_BITS-1:0] lookupTag,
    output logic [INDEX_BITS-1:0] lookupIndex,
    output logic touch,
    output logic fill,
    output logic fillStart,
    output logic [BLOCK_ADDR_BITS-1:0] fillAddr,
    output logic [BLOCK_BITS-1:0] lineData,
    output logic lineDone
);

    typedef enum logic [2:0] {stIdle, stLookup, stRefill, stWrite, stRespond} stateT;

    stateT state;

    // associativity must be a power of two from 2 to 8
    if (WAYS < 2 || WAYS > 8 || (WAYS & (WAYS - 1)) != 0) begin : gWaysCheck
        $error("unsupported associativity %0d", WAYS);
    end

    // the held fetch address drives the array and the refill
    assign lookupTag = fetchAddr.fields.tag;
    assign lookupIndex = fetchAddr.fields.index;
    assign fillAddr = {fetchAddr.fields.tag, fetchAddr.fields.index};

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= stIdle;
            touch <= 1'b0;
            fill <= 1'b0;
            fillStart <= 1'b0;
            lineDone <= 1'b0;
        end else begin
            touch <= 1'b0;
            fill <= 1'b0;
            fillStart <= 1'b0;
            lineDone <= 1'b0;
            case (state)
                stIdle: begin
                    if (lookupStart && hit) begin
                        touch <= 1'b1;
                        lineDone <= 1'b1;
                        state <= stLookup;
                    end else if (lookupStart) begin
                        fillStart <= 1'b1;
                        state <= stRefill;
                    end
                end
                // hit line is on its way back, MRU update in flight
                stLookup: state <= stIdle;
                stRefill: begin
                    if (fillDone) begin
                        fill <= 1'b1;
                        state <= stWrite;
                    end
                end
                // array takes the block at the end of this cycle
                stWrite: begin
                    lineDone <= 1'b1;
                    state <= stRespond;
                end
                default: state <= stIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == stIdle && lookupStart && hit) begin
            lineData <= hitData;
        end else if (state == stRefill && fillDone) begin
            lineData <= fillData;
        end
    end

endmodule

//--- hdl/icacheTop.sv
// Top level of the read-only instruction cache. CPU fetch port on one side,
// block refill port to backing memory on the other, lookup controller and
// tag/data array in between. WAYS sets the associativity.
`timescale 1ns/1ps

module icacheTop import icachePkg::*; #(
    parameter int WAYS = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic cpuReq,
    input  fetchAddrT cpuAddr,
    output logic cpuAck,
    output logic [WORD_BITS-1:0] cpuData,
    output logic memReq,
    output logic [BLOCK_ADDR_BITS-1:0] memAddr,
    input  logic memAck,
    input  logic [BLOCK_BITS-1:0] memData
);

    fetchAddrT fetchAddr;
    logic lookupStart;
    logic lineDone;
    logic [BLOCK_BITS-1:0] lineData;

    logic [TAG_BITS-1:0] lookupTag;
    logic [INDEX_BITS-1:0] lookupIndex;
    logic hit;
    logic [BLOCK_BITS-1:0] hitData;
    logic touch;
    logic fill;

    logic fillStart;
    logic fillDone;
    logic [BLOCK_ADDR_BITS-1:0] fillAddr;
    logic [BLOCK_BITS-1:0] fillData;

    fetchPort uFetchPort (
        .clk(clk), .rst(rst),
        .cpuReq(cpuReq), .cpuAddr(cpuAddr), .cpuAck(cpuAck), .cpuData(cpuData),
        .lineData(lineData), .lineDone(lineDone),
        .lookupStart(lookupStart), .fetchAddr(fetchAddr)
    );

    cacheCtrl #(.WAYS(WAYS)) uCacheCtrl (
        .clk(clk), .rst(rst),
        .lookupStart(lookupStart), .fetchAddr(fetchAddr),
        .hit(hit), .hitData(hitData),
        .fillDone(fillDone), .fillData(fillData),
        .lookupTag(lookupTag), .lookupIndex(lookupIndex),
        .touch(touch), .fill(fill),
        .fillStart(fillStart), .fillAddr(fillAddr),
        .lineData(lineData), .lineDone(lineDone)
    );

    cacheArray #(.WAYS(WAYS)) uCacheArray (
        .clk(clk), .rst(rst),
        .lookupTag(lookupTag), .lookupIndex(lookupIndex),
        .touch(touch), .fill(fill), .fillData(fillData),
        .hit(hit), .hitData(hitData)
    );

    memPort uMemPort (
        .clk(clk), .rst(rst),
        .fillStart(fillStart), .fillAddr(fillAddr),
        .memAck(memAck), .memData(memData),
        .memReq(memReq), .memAddr(memAddr),
        .fillDone(fillDone), .fillData(fillData)
    );

endmodule

//--- verif/backingMem.sv
// Behavioral backing memory for the instruction cache testbench.
// Answers each four-phase block request after ackDelay cycles with a block
// whose words follow from the block address, and lets the ack go ackDelay
// cycles after the request drops.
`timescale 1ns/1ps

module backingMem import icachePkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic memReq,
    input  logic [BLOCK_ADDR_BITS-1:0] memAddr,
    input  logic [3:0] ackDelay,
    output logic memAck,
    output logic [BLOCK_BITS-1:0] memData
);

    logic ackQ = 1'b0;
    logic [BLOCK_BITS-1:0] dataQ = '0;
    logic [3:0] waitCount = '0;

    assign memAck = ackQ;
    assign memData = dataQ;

    // word n of block B holds B*4+n with a fixed pattern on top
    function automatic logic [BLOCK_BITS-1:0] blockContents(
        input logic [BLOCK_ADDR_BITS-1:0] blk
    );
        logic [BLOCK_BITS-1:0] data;
        for (int n = 0; n < BLOCK_WORDS; n++) begin
            data[n*WORD_BITS +: WORD_BITS] = (32'(blk) * 4 + 32'(n)) ^ 32'h5A5A_0000;
        end
        return data;
    endfunction

    // responds on the falling edge away from the DUT's sampling edge
    always @(negedge clk or negedge rst) begin
        if (!rst) begin
            ackQ <= 1'b0;
            waitCount <= '0;
        end else if (ackQ) begin
            // slow release once the request is gone
            if (!memReq) begin
                if (waitCount >= ackDelay) begin
                    ackQ <= 1'b0;
                    waitCount <= '0;
                end else begin
                    waitCount <= waitCount + 4'd1;
                end
            end
        end else if (memReq) begin
            if (waitCount >= ackDelay) begin
                ackQ <= 1'b1;
                dataQ <= blockContents(memAddr);
                waitCount <= '0;
            end else begin
                waitCount <= waitCount + 4'd1;
            end
        end
    end

endmodule

//--- verif/icacheHandshake_props.sv
// Concurrent checks on the CPU and memory handshakes of the instruction cache.
// Bound into icacheTop; failCount lets the testbench see any failure.
`timescale 1ns/1ps

module icacheHandshake_props (
    input  logic clk,
    input  logic rst,
    input  logic cpuReq,
    input  logic cpuAck,
    input  logic memReq,
    input  logic memAck
);

    int failCount = 0;

    // ack only answers a live request
    ackNeedsReq: assert property (@(posedge clk) disable iff (!rst)
        $rose(cpuAck) |-> $past(cpuReq))
        else begin
            failCount++;
            $error("cpuAck rose while cpuReq was low");
        end

    memReqHolds: assert property (@(posedge clk) disable iff (!rst)
        (memReq && !memAck) |=> memReq)
        else begin
            failCount++;
            $error("memReq dropped before memAck arrived");
        end

    // no new request until the previous ack is gone
    memReqWaitsAckLow: assert property (@(posedge clk) disable iff (!rst)
        (!memReq && memAck) |=> !memReq)
        else begin
            failCount++;
            $error("memReq rose while memAck was still high");
        end

    quietAfterReset: assert property (@(posedge clk)
        $rose(rst) |-> (!cpuAck && !memReq))
        else begin
            failCount++;
            $error("cpuAck or memReq high when reset was released");
        end

endmodule

bind icacheTop icacheHandshake_props uProps (
    .clk(clk), .rst(rst),
    .cpuReq(cpuReq), .cpuAck(cpuAck),
    .memReq(memReq), .memAck(memAck)
);

//--- verif/icacheTb.sv
// Directed testbench for the instruction cache. Runs cold miss, hit, replacement,
// reset and random fetch tests against a behavioral backing memory and a small
// reference model of the MRU replacement, then prints a summary line.
`timescale 1ns/1ps

module icacheTb import icachePkg::*; ();

    localparam int TB_WAYS = 4;
    localparam int RESET_CYCLES = 16;
    localparam int RANDOM_FETCHES = 48;
    localparam int FETCHES = 1 + 3 + 10 + 1 + RANDOM_FETCHES;
    // handshakes, refill steps and the longest memory delay of one miss
    localparam int MISS_WORST = 28;
    localparam int CYCLE_LIMIT = FETCHES * MISS_WORST + 3 * RESET_CYCLES + 64;

    logic clk;
    logic rst;
    logic cpuReq;
    fetchAddrT cpuAddr;
    logic cpuAck;
    logic [WORD_BITS-1:0] cpuData;
    logic memReq;
    logic [BLOCK_ADDR_BITS-1:0] memAddr;
    logic memAck;
    logic [BLOCK_BITS-1:0] memData;
    logic [3:0] memDelay;

    int errorCount = 0;
    int cycleCount = 0;
    int memReqCount = 0;
    logic memReqPrev = 1'b0;
    int lastAckCycles;
    logic [15:0] lfsrState = 16'd83;

    // reference model of valid, MRU and tag per set and way
    logic [TB_WAYS-1:0] modelValid [SETS];
    logic [TB_WAYS-1:0] modelMru [SETS];
    logic [TAG_BITS-1:0] modelTag [SETS][TB_WAYS];

    icacheTop #(.WAYS(TB_WAYS)) DUT (
        .clk(clk), .rst(rst),
        .cpuReq(cpuReq), .cpuAddr(cpuAddr), .cpuAck(cpuAck), .cpuData(cpuData),
        .memReq(memReq), .memAddr(memAddr), .memAck(memAck), .memData(memData)
    );

    backingMem uMem (
        .clk(clk), .rst(rst),
        .memReq(memReq), .memAddr(memAddr), .ackDelay(memDelay),
        .memAck(memAck), .memData(memData)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // count refills by rising memReq
    always @(negedge clk) begin
        memReqPrev <= memReq;
        if (memReq && !memReqPrev) begin
            memReqCount++;
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, a fetch never completed", cycleCount);
            $display("Test failed");
            $finish;
        end
    end

    // galois LFSR, one step per bit taken
    function automatic logic [15:0] randomBits(input int count);
        logic [15:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[14:0], lfsrState[0]};
            lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 16'hB400) : (lfsrState >> 1);
        end
        return value;
    endfunction

    // word n of block B is B*4+n xor 0x5A5A0000
    function automatic logic [WORD_BITS-1:0] expectedWord(input fetchAddrT addr);
        logic [BLOCK_ADDR_BITS-1:0] blk;
        blk = {addr.fields.tag, addr.fields.index};
        return (32'(blk) * 4 + 32'(addr.fields.wordSel)) ^ 32'h5A5A_0000;
    endfunction

    function automatic void clearModel();
        for (int s = 0; s < SETS; s++) begin
            modelValid[s] = '0;
            modelMru[s] = '0;
        end
    endfunction

    // returns 1 on a miss and updates the model like the cache would
    function automatic logic modelAccess(input fetchAddrT addr);
        int idx;
        int way;
        logic miss;
        logic [TB_WAYS-1:0] mask;
        idx = int'(addr.fields.index);
        way = -1;
        for (int w = TB_WAYS - 1; w >= 0; w--) begin
            if (modelValid[idx][w] && modelTag[idx][w] == addr.fields.tag) begin
                way = w;
            end
        end
        miss = (way < 0);
        if (miss) begin
            // lowest MRU-clear way, overridden by the lowest invalid one
            way = 0;
            for (int w = TB_WAYS - 1; w >= 0; w--) begin
                if (!modelMru[idx][w]) way = w;
            end
            for (int w = TB_WAYS - 1; w >= 0; w--) begin
                if (!modelValid[idx][w]) way = w;
            end
            modelValid[idx][way] = 1'b1;
            modelTag[idx][way] = addr.fields.tag;
        end
        mask = TB_WAYS'(1) << way;
        modelMru[idx] = modelMru[idx] | mask;
        if (&modelMru[idx]) begin
            modelMru[idx] = mask;
        end
        return miss;
    endfunction

    task automatic checkWord(input string testName, input logic [WORD_BITS-1:0] expected,
                             input logic [WORD_BITS-1:0] actual);
        if (actual !== expected) begin
            errorCount++;
            $display("ERROR %s: expected word %h, actual %h", testName, expected, actual);
        end
    endtask

    task automatic checkCount(input string testName, input int expected, input int actual);
        if (actual != expected) begin
            errorCount++;
            $display("ERROR %s: expected %0d memory requests, actual %0d",
                     testName, expected, actual);
        end
    endtask

    task automatic checkLatency(input string testName, input int expected, input int actual);
        if (actual != expected) begin
            errorCount++;
            $display("ERROR %s: expected ack after %0d cycles, actual %0d",
                     testName, expected, actual);
        end
    endtask

    task automatic applyReset();
        @(negedge clk);
        rst = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b1;
    endtask

    // one full four-phase fetch, latency counted from the sampling edge
    task automatic fetchWord(input fetchAddrT addr, input logic [3:0] delay,
                             output logic [WORD_BITS-1:0] data);
        int waited;
        @(negedge clk);
        memDelay = delay;
        cpuAddr = addr;
        cpuReq = 1'b1;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!cpuAck);
        lastAckCycles = waited - 1;
        data = cpuData;
        cpuReq = 1'b0;
        do @(negedge clk); while (cpuAck);
    endtask

    task automatic fetchAndCompare(input string testName, input fetchAddrT addr,
                                   input logic [3:0] delay, inout int expMisses);
        logic [WORD_BITS-1:0] word;
        if (modelAccess(addr)) expMisses++;
        fetchWord(addr, delay, word);
        checkWord(testName, expectedWord(addr), word);
    endtask

    task automatic coldMissTest();
        int expMisses;
        int startCount;
        fetchAddrT addr;
        expMisses = 0;
        startCount = memReqCount;
        addr.raw = 32'h0000_1230;
        fetchAndCompare("coldMiss", addr, 4'd2, expMisses);
        checkCount("coldMiss", 1, memReqCount - startCount);
    endtask

    task automatic hitTest();
        int expMisses;
        int startCount;
        fetchAddrT addr;
        expMisses = 0;
        startCount = memReqCount;
        for (int n = 1; n < BLOCK_WORDS; n++) begin
            addr.raw = 32'h0000_1230 + 32'(4 * n);
            fetchAndCompare("hits", addr, 4'd2, expMisses);
            checkLatency("hits", 2, lastAckCycles);
        end
        checkCount("hits", 0, memReqCount - startCount);
    endtask

    // five blocks into set 5, then every one of them again
    task automatic replacementTest();
        int expMisses;
        int startCount;
        fetchAddrT addr;
        expMisses = 0;
        startCount = memReqCount;
        for (int pass = 0; pass < 2; pass++) begin
            for (int b = 0; b < 5; b++) begin
                addr.raw = '0;
                addr.fields.tag = 24'h000300 + 24'(b);
                addr.fields.index = 4'd5;
                addr.fields.wordSel = 2'(b + pass);
                fetchAndCompare("replacement", addr, 4'd3, expMisses);
            end
        end
        checkCount("replacement", expMisses, memReqCount - startCount);
    endtask

    task automatic resetTest();
        int expMisses;
        int startCount;
        fetchAddrT addr;
        applyReset();
        clearModel();
        expMisses = 0;
        startCount = memReqCount;
        addr.raw = 32'h0000_1230;
        fetchAndCompare("reset", addr, 4'd1, expMisses);
        checkCount("reset", 1, memReqCount - startCount);
    endtask

    task automatic randomTest();
        int expMisses;
        int startCount;
        fetchAddrT addr;
        logic [3:0] delay;
        expMisses = 0;
        startCount = memReqCount;
        for (int i = 0; i < RANDOM_FETCHES; i++) begin
            delay = 4'(randomBits(3));
            addr.raw = '0;
            addr.fields.tag = 24'h000040 + 24'(randomBits(3));
            addr.fields.index = 4'd8 + 4'(randomBits(1));
            addr.fields.wordSel = 2'(randomBits(2));
            fetchAndCompare("random", addr, delay, expMisses);
        end
        checkCount("random", expMisses, memReqCount - startCount);
    endtask

    initial begin
        int assertFails;
        rst = 1'b0;
        cpuReq = 1'b0;
        cpuAddr.raw = '0;
        memDelay = 4'd2;
        clearModel();
        applyReset();
        coldMissTest();
        hitTest();
        replacementTest();
        resetTest();
        randomTest();
        repeat (4) @(negedge clk);
        assertFails = DUT.uProps.failCount;
        $display("summary: %0d check errors, %0d assertion failures",
                 errorCount, assertFails);
        if (errorCount == 0 && assertFails == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- filelist.f
hdl/icachePkg.sv
hdl/fetchPort.sv
hdl/cacheArray.sv
hdl/memPort.sv
hdl/cacheCtrl.sv
hdl/icacheTop.sv
verif/backingMem.sv
verif/icacheHandshake_props.sv
verif/icacheTb.sv

//--- Makefile
# Verilator build and run of the instruction cache testbench.
# Override any variable on the command line, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP ?= icacheTb
FILELIST ?= filelist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0
SIMARGS ?= +verilator+error+limit+1000
PASS_TEXT ?= Test completed successfully

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) $(SIMARGS) 2>&1 | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
